// ==== source/mul_config.svh ====
// Widths are fixed for RV32; changing MUL_XLEN alone does not resize the multiplier core
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// Operand width of the integer datapath
`define MUL_XLEN 32

// Destination register tag carried with each request
`define MUL_TAG_W 5

// Cycles from core start to finished
`define MUL_CORE_LAT 3

`endif

// ==== source/mul_pkg.sv ====
// Types for the RV32 multiply unit; funct3 codes 4 to 7 are divide ops and are not handled here
`default_nettype none

`include "mul_config.svh"

package mul_pkg;

	// M-extension funct3 for the multiply group
	typedef enum logic [2:0] {
		MUL    = 3'd0,
		MULH   = 3'd1,
		MULHSU = 3'd2,
		MULHU  = 3'd3
	} mul_op_e;

	// Incoming request, rs1 is the multiplicand
	typedef struct packed {
		mul_op_e               op;
		logic [`MUL_XLEN-1:0]  rs1;
		logic [`MUL_XLEN-1:0]  rs2;
		logic [`MUL_TAG_W-1:0] rd;
	} mul_req_t;

	// Control that rides alongside the core pipeline
	typedef struct packed {
		logic                  high;
		logic [`MUL_TAG_W-1:0] rd;
	} mul_ctrl_t;

	// Tagged writeback
	typedef struct packed {
		logic [`MUL_TAG_W-1:0] rd;
		logic [`MUL_XLEN-1:0]  data;
	} mul_resp_t;

endpackage

`default_nettype wire

// ==== source/mul_csa.sv ====
// Plain 3:2 compressor; the carry output is pre-shifted and its top bit is dropped
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_csa #(
	parameter int WIDTH = 2 * `MUL_XLEN
) (
	input  logic [WIDTH-1:0] x,
	input  logic [WIDTH-1:0] y,
	input  logic [WIDTH-1:0] z,
	output logic [WIDTH-1:0] sum,
	output logic [WIDTH-1:0] cout
);

	assign sum = x ^ y ^ z;

	// Majority moved up one weight
	assign cout = ((x & y) | (y & z) | (x & z)) << 1;

endmodule

`default_nettype wire

// ==== source/rv32v_multiplier.sv ====
// Fixed 32x32 core, three cycles from start to finished, accepts a new operand pair every cycle
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module rv32v_multiplier (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic [`MUL_XLEN-1:0]    multiplicand,
	input  logic [`MUL_XLEN-1:0]    multiplier,
	input  logic [1:0]              is_signed,
	input  logic                    start,
	output logic                    finished,
	output logic [2*`MUL_XLEN-1:0]  product
);

	// Captured operands
	logic [31:0] mcand_q;
	logic [31:0] mplier_q;
	logic [1:0]  is_signed_q;

	// Stage 1 combinational
	logic [31:0] mcand_mag;
	logic [31:0] mplier_mag;
	logic        negate_s1;
	logic [32:0] booth_in;
	logic [63:0] pos1, pos2, neg1, neg2;
	logic [63:0] pp_s1 [16];

	// Stage 1 registers
	logic [63:0] pp_q [16];
	logic [31:0] mcand_mag_q1;
	logic        fix_q1;
	logic        negate_q1;

	// Tree nets
	logic [63:0] csa_s [14];
	logic [63:0] csa_c [14];

	// Stage 2 registers
	logic [63:0] tree_q [8];
	logic [31:0] mcand_mag_q2;
	logic        fix_q2;
	logic        negate_q2;

	// Final add
	logic [63:0] sum_cp;
	logic [63:0] sum_fixed;

	logic [2:0]  start_sr;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mcand_q     <= '0;
			mplier_q    <= '0;
			is_signed_q <= '0;
		end else if (start) begin
			mcand_q     <= multiplicand;
			mplier_q    <= multiplier;
			is_signed_q <= is_signed;
		end
	end

	// Work on magnitudes, sign is restored at the end
	assign mcand_mag  = (is_signed_q[1] && mcand_q[31]) ? (~mcand_q + 32'd1) : mcand_q;
	assign mplier_mag = (is_signed_q[0] && mplier_q[31]) ? (~mplier_q + 32'd1) : mplier_q;
	assign negate_s1  = (is_signed_q[1] & mcand_q[31]) ^ (is_signed_q[0] & mplier_q[31]);

	assign booth_in = {mplier_mag, 1'b0};
	assign pos1     = {32'd0, mcand_mag};
	assign pos2     = pos1 << 1;
	assign neg1     = ~pos1 + 64'd1;
	assign neg2     = ~pos2 + 64'd1;

	// Radix-4 recoding, one digit per bit pair
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			case (booth_in[2*i +: 3])
				3'b001, 3'b010: pp_s1[i] = pos1 << (2 * i);
				3'b011:         pp_s1[i] = pos2 << (2 * i);
				3'b100:         pp_s1[i] = neg2 << (2 * i);
				3'b101, 3'b110: pp_s1[i] = neg1 << (2 * i);
				default:        pp_s1[i] = '0;
			endcase
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 16; i++) begin
				pp_q[i] <= '0;
			end
			mcand_mag_q1 <= '0;
			fix_q1       <= 1'b0;
			negate_q1    <= 1'b0;
		end else begin
			for (int i = 0; i < 16; i++) begin
				pp_q[i] <= pp_s1[i];
			end
			mcand_mag_q1 <= mcand_mag;
			// Booth read the magnitude as signed, so a set top bit needs +M<<32
			fix_q1       <= mplier_mag[31];
			negate_q1    <= negate_s1;
		end
	end

	// Layer 1, pp15 waits for later
	mul_csa #(64) u_csa0 (.x(pp_q[0]),  .y(pp_q[1]),  .z(pp_q[2]),  .sum(csa_s[0]), .cout(csa_c[0]));
	mul_csa #(64) u_csa1 (.x(pp_q[3]),  .y(pp_q[4]),  .z(pp_q[5]),  .sum(csa_s[1]), .cout(csa_c[1]));
	mul_csa #(64) u_csa2 (.x(pp_q[6]),  .y(pp_q[7]),  .z(pp_q[8]),  .sum(csa_s[2]), .cout(csa_c[2]));
	mul_csa #(64) u_csa3 (.x(pp_q[9]),  .y(pp_q[10]), .z(pp_q[11]), .sum(csa_s[3]), .cout(csa_c[3]));
	mul_csa #(64) u_csa4 (.x(pp_q[12]), .y(pp_q[13]), .z(pp_q[14]), .sum(csa_s[4]), .cout(csa_c[4]));

	// Layer 2
	mul_csa #(64) u_csa5 (.x(csa_c[0]), .y(csa_s[0]), .z(csa_c[1]), .sum(csa_s[5]), .cout(csa_c[5]));
	mul_csa #(64) u_csa6 (.x(csa_s[1]), .y(csa_c[2]), .z(csa_s[2]), .sum(csa_s[6]), .cout(csa_c[6]));
	mul_csa #(64) u_csa7 (.x(csa_c[3]), .y(csa_s[3]), .z(csa_c[4]), .sum(csa_s[7]), .cout(csa_c[7]));

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 8; i++) begin
				tree_q[i] <= '0;
			end
			mcand_mag_q2 <= '0;
			fix_q2       <= 1'b0;
			negate_q2    <= 1'b0;
		end else begin
			tree_q[0]    <= csa_c[5];
			tree_q[1]    <= csa_s[5];
			tree_q[2]    <= csa_c[6];
			tree_q[3]    <= csa_s[6];
			tree_q[4]    <= csa_c[7];
			tree_q[5]    <= csa_s[7];
			tree_q[6]    <= pp_q[15];
			tree_q[7]    <= csa_s[4];
			mcand_mag_q2 <= mcand_mag_q1;
			fix_q2       <= fix_q1;
			negate_q2    <= negate_q1;
		end
	end

	// Layers 3 to 6 down to one sum and one carry
	mul_csa #(64) u_csa8 (.x(tree_q[0]), .y(tree_q[1]), .z(tree_q[2]), .sum(csa_s[8]), .cout(csa_c[8]));
	mul_csa #(64) u_csa9 (.x(tree_q[3]), .y(tree_q[4]), .z(tree_q[5]), .sum(csa_s[9]), .cout(csa_c[9]));
	mul_csa #(64) u_csa10 (
		.x(csa_c[8]), .y(csa_s[8]), .z(csa_c[9]), .sum(csa_s[10]), .cout(csa_c[10])
	);
	mul_csa #(64) u_csa11 (
		.x(csa_s[9]), .y(tree_q[6]), .z(tree_q[7]), .sum(csa_s[11]), .cout(csa_c[11])
	);
	mul_csa #(64) u_csa12 (
		.x(csa_c[10]), .y(csa_s[10]), .z(csa_c[11]), .sum(csa_s[12]), .cout(csa_c[12])
	);
	mul_csa #(64) u_csa13 (
		.x(csa_c[12]), .y(csa_s[12]), .z(csa_s[11]), .sum(csa_s[13]), .cout(csa_c[13])
	);

	assign sum_cp    = csa_c[13] + csa_s[13];
	assign sum_fixed = fix_q2 ? (sum_cp + {mcand_mag_q2, 32'd0}) : sum_cp;
	assign product   = negate_q2 ? (~sum_fixed + 64'd1) : sum_fixed;

	// finished tracks start through the three register stages
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			start_sr <= '0;
		end else begin
			start_sr <= {start_sr[1:0], start};
		end
	end

	assign finished = start_sr[2];

endmodule

`default_nettype wire

// ==== source/mul_decode.sv ====
// Combinational decode of one request per cycle; divide funct3 codes only raise illegal
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_decode (
	input  logic                 CLK,
	input  logic                 nRST,
	input  logic                 req_valid,
	input  mul_pkg::mul_req_t    req,
	output logic                 start,
	output logic [`MUL_XLEN-1:0] multiplicand,
	output logic [`MUL_XLEN-1:0] multiplier,
	output logic [1:0]           is_signed,
	output mul_pkg::mul_ctrl_t   ctrl,
	output logic                 illegal
);

	logic illegal_d;

	// funct3 bit 2 selects the divide group
	assign start     = req_valid && !req.op[2];
	assign illegal_d = req_valid && req.op[2];

	assign multiplicand = req.rs1;
	assign multiplier   = req.rs2;

	// Bit 1 for rs1, bit 0 for rs2
	always_comb begin
		case (req.op)
			mul_pkg::MULH:   is_signed = 2'b11;
			mul_pkg::MULHSU: is_signed = 2'b10;
			default:         is_signed = 2'b00;
		endcase
	end

	assign ctrl.high = (req.op != mul_pkg::MUL);
	assign ctrl.rd   = req.rd;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			illegal <= 1'b0;
		end else begin
			illegal <= illegal_d;
		end
	end

endmodule

`default_nettype wire

// ==== source/mul_result.sv ====
// Control delay must equal the core latency; resp data is only meaningful while resp_valid is high
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_result (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic                     start,
	input  logic                     finished,
	input  mul_pkg::mul_ctrl_t       ctrl,
	input  logic [2*`MUL_XLEN-1:0]   product,
	output logic                     resp_valid,
	output mul_pkg::mul_resp_t       resp
);

	// Entry 0 is loaded at the core's capture edge
	mul_pkg::mul_ctrl_t ctrl_q [`MUL_CORE_LAT];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `MUL_CORE_LAT; i++) begin
				ctrl_q[i] <= '0;
			end
		end else begin
			if (start) begin
				ctrl_q[0] <= ctrl;
			end
			for (int i = 1; i < `MUL_CORE_LAT; i++) begin
				ctrl_q[i] <= ctrl_q[i-1];
			end
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= finished;
		end
	end

	// Half select on the last entry, which lines up with finished
	always_ff @(posedge CLK) begin
		if (finished) begin
			resp.rd <= ctrl_q[`MUL_CORE_LAT-1].rd;
			if (ctrl_q[`MUL_CORE_LAT-1].high) begin
				resp.data <= product[2*`MUL_XLEN-1:`MUL_XLEN];
			end else begin
				resp.data <= product[`MUL_XLEN-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/mul_unit.sv ====
// No back-pressure and no flush; responses return in order four cycles after a legal request
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_unit (
	input  logic               CLK,
	input  logic               nRST,
	input  logic               req_valid,
	input  mul_pkg::mul_req_t  req,
	output logic               resp_valid,
	output mul_pkg::mul_resp_t resp,
	output logic               illegal
);

	logic                    start;
	logic                    finished;
	logic [`MUL_XLEN-1:0]    multiplicand;
	logic [`MUL_XLEN-1:0]    multiplier;
	logic [1:0]              is_signed;
	logic [2*`MUL_XLEN-1:0]  product;
	mul_pkg::mul_ctrl_t      ctrl;

	mul_decode u_decode (
		.CLK          (CLK),
		.nRST         (nRST),
		.req_valid    (req_valid),
		.req          (req),
		.start        (start),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.is_signed    (is_signed),
		.ctrl         (ctrl),
		.illegal      (illegal)
	);

	rv32v_multiplier u_core (
		.CLK          (CLK),
		.nRST         (nRST),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.is_signed    (is_signed),
		.start        (start),
		.finished     (finished),
		.product      (product)
	);

	mul_result u_result (
		.CLK        (CLK),
		.nRST       (nRST),
		.start      (start),
		.finished   (finished),
		.ctrl       (ctrl),
		.product    (product),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

endmodule

`default_nettype wire

// ==== testbench/mul_unit_chk.sv ====
// Timing checks for mul_unit; latency follows MUL_CORE_LAT and the reset is asynchronous
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_unit_chk (
	input logic CLK,
	input logic nRST,
	input logic start,
	input logic finished,
	input logic resp_valid,
	input logic illegal
);

	// Number of failed checks
	int fail_count = 0;

	// Core returns exactly MUL_CORE_LAT edges after start
	a_start_finished: assert property (@(posedge CLK) disable iff (!nRST)
		start |-> ##(`MUL_CORE_LAT) finished)
	else begin
		fail_count++;
		$error("finished did not follow start after the core latency");
	end

	a_finished_resp: assert property (@(posedge CLK) disable iff (!nRST)
		finished |=> resp_valid)
	else begin
		fail_count++;
		$error("resp_valid did not follow finished");
	end

	// A request that started the core never raises illegal
	a_start_not_illegal: assert property (@(posedge CLK) disable iff (!nRST)
		start |=> !illegal)
	else begin
		fail_count++;
		$error("illegal raised for a request that reached the core");
	end

	a_reset_quiet: assert property (@(posedge CLK)
		!nRST |=> !resp_valid && !illegal)
	else begin
		fail_count++;
		$error("outputs not low during reset");
	end

endmodule

bind mul_unit mul_unit_chk u_chk (
	.CLK        (CLK),
	.nRST       (nRST),
	.start      (start),
	.finished   (finished),
	.resp_valid (resp_valid),
	.illegal    (illegal)
);

`default_nettype wire

// ==== testbench/mul_unit_tb.sv ====
// Responses are checked in request order with no fixed latency; the timeout scales with request count
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_unit_tb;

	localparam int DIR_REQS  = 7 * 7 * 4 + 3 * 4;
	localparam int RAND_REQS = 400;
	localparam int MIX_REQS  = 4 * 3;
	// One cycle per request, doubled, plus reset, idle gaps and draining
	localparam int MAX_CYCLES = 2 * (DIR_REQS + RAND_REQS + MIX_REQS) + 100;

	logic               CLK;
	logic               nRST;
	logic               req_valid;
	mul_pkg::mul_req_t  req;
	logic               resp_valid;
	mul_pkg::mul_resp_t resp;
	logic               illegal;

	mul_pkg::mul_resp_t   exp_q [$];
	logic [`MUL_XLEN-1:0] patterns [7];
	int seed;
	int mismatch_errors;
	int other_errors;
	int legal_sent;
	int illegal_sent;
	int resp_seen;
	int illegal_seen;
	int cycle_count;

	mul_unit dut (
		.CLK        (CLK),
		.nRST       (nRST),
		.req_valid  (req_valid),
		.req        (req),
		.resp_valid (resp_valid),
		.resp       (resp),
		.illegal    (illegal)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#2 CLK = ~CLK;
		end
	end

	// Expected writeback value from the M-extension definition
	function automatic logic [`MUL_XLEN-1:0] ref_result(input logic [2:0] op,
			input logic [`MUL_XLEN-1:0] rs1, input logic [`MUL_XLEN-1:0] rs2);
		logic        s1;
		logic        s2;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] p;
		// rs1 signed for MULH and MULHSU, rs2 signed for MULH only
		s1 = (op == 3'd1) || (op == 3'd2);
		s2 = (op == 3'd1);
		a  = {{32{s1 & rs1[31]}}, rs1};
		b  = {{32{s2 & rs2[31]}}, rs2};
		p  = a * b;
		if (op == 3'd0) begin
			return p[31:0];
		end
		return p[63:32];
	endfunction

	// Called at a rising edge, returns at the next one
	task automatic send_req(input logic [2:0] op, input logic [`MUL_XLEN-1:0] rs1,
			input logic [`MUL_XLEN-1:0] rs2, input logic [`MUL_TAG_W-1:0] rd);
		mul_pkg::mul_resp_t expected;
		req_valid <= 1'b1;
		req.op    <= mul_pkg::mul_op_e'(op);
		req.rs1   <= rs1;
		req.rs2   <= rs2;
		req.rd    <= rd;
		if (op[2]) begin
			illegal_sent++;
		end else begin
			expected.rd   = rd;
			expected.data = ref_result(op, rs1, rs2);
			exp_q.push_back(expected);
			legal_sent++;
		end
		@(posedge CLK);
	endtask

	task automatic send_random_legal();
		logic [2:0]           op;
		logic [`MUL_XLEN-1:0] rs1;
		logic [`MUL_XLEN-1:0] rs2;
		logic [`MUL_TAG_W-1:0] rd;
		op  = 3'($random(seed) & 3);
		rs1 = $random(seed);
		rs2 = $random(seed);
		rd  = 5'($random(seed));
		send_req(op, rs1, rs2, rd);
	endtask

	task automatic idle_cycles(input int n);
		req_valid <= 1'b0;
		repeat (n) @(posedge CLK);
	endtask

	// Values read at the edge are the ones registered on the previous edge
	always @(posedge CLK) begin : compare
		mul_pkg::mul_resp_t expected;
		if (nRST && resp_valid === 1'b1) begin
			resp_seen++;
			if (exp_q.size() == 0) begin
				$display("Response for rd %h arrived with no request outstanding", resp.rd);
				other_errors++;
			end else begin
				expected = exp_q.pop_front();
				if (resp.rd !== expected.rd) begin
					$display("MISMATCH resp.rd: got %h, expected %h", resp.rd, expected.rd);
					mismatch_errors++;
				end
				if (resp.data !== expected.data) begin
					$display("MISMATCH resp.data: got %h, expected %h",
						resp.data, expected.data);
					mismatch_errors++;
				end
			end
		end
		if (nRST && illegal === 1'b1) begin
			illegal_seen++;
			if (illegal_seen > illegal_sent) begin
				$display("Illegal strobe seen without an illegal request");
				other_errors++;
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles with %0d responses still pending",
			cycle_count, exp_q.size());
		$display("Test failed");
		$finish;
	end

	initial begin
		seed            = 32'h785b;
		mismatch_errors = 0;
		other_errors    = 0;
		legal_sent      = 0;
		illegal_sent    = 0;
		resp_seen       = 0;
		illegal_seen    = 0;
		patterns[0]     = 32'h0000_0000;
		patterns[1]     = 32'h0000_0001;
		patterns[2]     = 32'hFFFF_FFFF;
		patterns[3]     = 32'h8000_0000;
		patterns[4]     = 32'hAAAA_AAAA;
		patterns[5]     = 32'h5555_5555;
		patterns[6]     = 32'h7FFF_FFFF;
		nRST            = 1'b0;
		req_valid       = 1'b0;
		req             = '0;
		repeat (5) @(posedge CLK);
		nRST <= 1'b1;

		// Quiet outputs before the first request
		repeat (8) begin
			@(posedge CLK);
			if (resp_valid !== 1'b0 || illegal !== 1'b0) begin
				$display("Output strobe seen before any request was sent");
				other_errors++;
			end
		end

		// Directed operand pairs through all four ops
		foreach (patterns[i]) begin
			foreach (patterns[j]) begin
				for (int op = 0; op < 4; op++) begin
					send_req(3'(op), patterns[i], patterns[j], 5'(i * 7 + j + op));
				end
			end
		end

		// Negative corners, low and high halves
		for (int op = 0; op < 4; op++) begin
			send_req(3'(op), 32'h8000_0000, 32'h8000_0000, 5'd1);
			send_req(3'(op), 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd2);
			send_req(3'(op), 32'h8000_0000, 32'hFFFF_FFFF, 5'd3);
		end
		idle_cycles(3);

		// Back-to-back traffic
		for (int n = 0; n < RAND_REQS; n++) begin
			send_random_legal();
		end
		idle_cycles(2);

		// Divide codes between legal neighbors
		for (int f = 4; f < 8; f++) begin
			send_random_legal();
			send_req(3'(f), $random(seed), $random(seed), 5'(f));
			send_random_legal();
		end
		idle_cycles(1);

		while (exp_q.size() != 0) begin
			@(posedge CLK);
		end
		// A few more cycles to catch stray strobes
		repeat (8) @(posedge CLK);

		if (resp_seen != legal_sent) begin
			$display("Got %0d responses for %0d legal requests", resp_seen, legal_sent);
			other_errors++;
		end
		if (illegal_seen != illegal_sent) begin
			$display("Got %0d illegal strobes for %0d illegal requests",
				illegal_seen, illegal_sent);
			other_errors++;
		end
		if (dut.u_chk.fail_count != 0) begin
			$display("Timing assertions failed %0d times", dut.u_chk.fail_count);
			other_errors++;
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/mul_pkg.sv
source/mul_csa.sv
source/rv32v_multiplier.sv
source/mul_decode.sv
source/mul_result.sv
source/mul_unit.sv
testbench/mul_unit_chk.sv
testbench/mul_unit_tb.sv

// ==== Bender.yml ====
package:
  name: mul_unit

export_include_dirs:
  - source

sources:
  - files:
      - source/mul_pkg.sv
      - source/mul_csa.sv
      - source/rv32v_multiplier.sv
      - source/mul_decode.sv
      - source/mul_result.sv
      - source/mul_unit.sv
  - target: test
    files:
      - testbench/mul_unit_chk.sv
      - testbench/mul_unit_tb.sv
